// ==== rtl/dim_pkg.sv ====
package dim_pkg;

	localparam int NUM_PORTS = 3;

	typedef logic [3:0] nibble_t;

	// one mii lane, dv qualifies the nibble
	typedef struct packed {
		logic    dv;
		nibble_t data;
	} mii_t;

	// header fields of a real-time frame
	typedef struct packed {
		logic        valid;
		logic [47:0] dest_mac;
		logic [15:0] eth_type;
		logic [7:0]  frt_type;
	} hdr_t;

	// timestamp triggers, slave role then master role
	typedef struct packed {
		logic frt0_s;
		logic sync_s;
		logic send_recvn_s;
		logic frt0_m;
		logic sync_m;
		logic send_recvn_m;
	} ts_trig_t;

	localparam logic [15:0] ETH_TYPE_RT = 16'h8907;

	localparam logic [7:0] FRT_TYPE_FRT0     = 8'h10;
	localparam logic [7:0] FRT_TYPE_SYNC_REQ = 8'h20;
	localparam logic [7:0] FRT_TYPE_SYNC_RSP = 8'h21;

	localparam logic [47:0] MAC_BCAST    = 48'hffff_ffff_ffff;
	localparam logic [47:0] MAC_SYNC_REQ = 48'h0100_5e00_0181;
	localparam logic [47:0] MAC_SYNC_RSP = 48'h0100_5e00_0182;

	// frt_type high nibble closes the header
	localparam int HDR_LAST_NIBBLE = 29;

endpackage

// ==== rtl/frame_parser.sv ====
`timescale 1ns/1ps

module frame_parser (
	input  logic          i_clk,
	input  logic          i_rst_n,
	input  dim_pkg::mii_t i_stream,
	output dim_pkg::hdr_t o_hdr
);

	// nibble windows of the header fields
	localparam int MAC_LAST   = 11;
	localparam int TYPE_FIRST = 24;
	localparam int FRT_FIRST  = 28;
	localparam int CNT_SAT    = dim_pkg::HDR_LAST_NIBBLE + 1;
	localparam int CNT_W      = $clog2(CNT_SAT + 1);

	logic [CNT_W-1:0] cnt;
	logic [5:0]       mac_pos;
	logic [3:0]       type_pos;
	logic [2:0]       frt_pos;

	// low nibble first, field bytes msb first
	always_comb
	begin
		mac_pos  = 6'(40 - 8 * int'(cnt >> 1) + 4 * int'(cnt[0]));
		type_pos = 4'(8 - 8 * (int'(cnt >> 1) - TYPE_FIRST / 2) + 4 * int'(cnt[0]));
		frt_pos  = 3'(4 * int'(cnt[0]));
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			cnt   <= '0;
			o_hdr <= '0;
		end
		else if (!i_stream.dv)
		begin
			// fields stay, only valid drops between frames
			cnt         <= '0;
			o_hdr.valid <= 1'b0;
		end
		else
		begin
			if (cnt != CNT_W'(CNT_SAT))
				cnt <= cnt + 1'b1;
			if (cnt <= CNT_W'(MAC_LAST))
				o_hdr.dest_mac[mac_pos +: 4] <= i_stream.data;
			if (cnt >= CNT_W'(TYPE_FIRST) && cnt < CNT_W'(FRT_FIRST))
				o_hdr.eth_type[type_pos +: 4] <= i_stream.data;
			if (cnt >= CNT_W'(FRT_FIRST) && cnt <= CNT_W'(dim_pkg::HDR_LAST_NIBBLE))
				o_hdr.frt_type[frt_pos +: 4] <= i_stream.data;
			if (cnt == CNT_W'(dim_pkg::HDR_LAST_NIBBLE))
				o_hdr.valid <= 1'b1;
		end
	end

endmodule

// ==== rtl/frame_delay.sv ====
`timescale 1ns/1ps

module frame_delay #(
	parameter int FWD_DELAY = 16
) (
	input  logic          i_clk,
	input  logic          i_rst_n,
	input  dim_pkg::mii_t i_stream,
	output dim_pkg::mii_t o_stream
);

	// cache stages, oldest nibble at the top index
	dim_pkg::mii_t pipe [FWD_DELAY];

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			for (int i = 0; i < FWD_DELAY; i++)
				pipe[i] <= '0;
		end
		else
		begin
			pipe[0] <= i_stream;
			for (int i = 1; i < FWD_DELAY; i++)
				pipe[i] <= pipe[i-1];
		end
	end

	assign o_stream = pipe[FWD_DELAY-1];

endmodule

// ==== rtl/port_tx_arbiter.sv ====
`timescale 1ns/1ps

module port_tx_arbiter #(
	parameter int PORT_ID = 0
) (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  logic                          i_sendtrig,
	input  dim_pkg::mii_t                 i_host,
	input  dim_pkg::mii_t                 i_fwd [dim_pkg::NUM_PORTS],
	input  logic [dim_pkg::NUM_PORTS-1:0] i_rx_dv,
	output dim_pkg::mii_t                 o_tx
);

	localparam int NP = dim_pkg::NUM_PORTS;

	// the two neighbours of this port
	localparam int LO_ID = (PORT_ID == 0) ? 1 : 0;
	localparam int HI_ID = (PORT_ID == 2) ? 1 : 2;

	// raw rx ports that hold off each neighbour
	localparam logic [NP-1:0] LO_MASK = NP'((1 << LO_ID) - 1);
	localparam logic [NP-1:0] HI_MASK = NP'((1 << HI_ID) - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SEND_SELF,
		ST_FWD_LO,
		ST_FWD_HI
	} state_t;

	state_t state;
	state_t state_nxt;

	logic trig_d;
	logic host_dv_d;
	logic lo_dv_d;
	logic hi_dv_d;
	logic trig_rise;
	logic host_end;
	logic lo_start;
	logic lo_end;
	logic hi_start;
	logic hi_end;

	assign trig_rise = i_sendtrig && !trig_d;
	assign host_end  = host_dv_d && !i_host.dv;
	assign lo_end    = lo_dv_d && !i_fwd[LO_ID].dv;
	assign hi_end    = hi_dv_d && !i_fwd[HI_ID].dv;

	// cached frame may start only if no lower port is receiving
	assign lo_start = i_fwd[LO_ID].dv && !lo_dv_d && ((i_rx_dv & LO_MASK) == '0);
	assign hi_start = i_fwd[HI_ID].dv && !hi_dv_d && ((i_rx_dv & HI_MASK) == '0);

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			trig_d    <= 1'b0;
			host_dv_d <= 1'b0;
			lo_dv_d   <= 1'b0;
			hi_dv_d   <= 1'b0;
		end
		else
		begin
			trig_d    <= i_sendtrig;
			host_dv_d <= i_host.dv;
			lo_dv_d   <= i_fwd[LO_ID].dv;
			hi_dv_d   <= i_fwd[HI_ID].dv;
		end
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
				if (trig_rise)
					state_nxt = ST_SEND_SELF;
				else if (lo_start)
					state_nxt = ST_FWD_LO;
				else if (hi_start)
					state_nxt = ST_FWD_HI;
			ST_SEND_SELF:
				if (host_end)
					state_nxt = ST_IDLE;
			ST_FWD_LO:
				if (lo_end)
					state_nxt = ST_IDLE;
				else if (trig_rise)
					state_nxt = ST_SEND_SELF;
			ST_FWD_HI:
				if (hi_end)
					state_nxt = ST_IDLE;
				else if (trig_rise)
					state_nxt = ST_SEND_SELF;
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	// tx follows the source picked by the next state
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= ST_IDLE;
			o_tx  <= '0;
		end
		else
		begin
			state <= state_nxt;
			case (state_nxt)
				ST_SEND_SELF: o_tx <= i_host;
				ST_FWD_LO:    o_tx <= i_fwd[LO_ID];
				ST_FWD_HI:    o_tx <= i_fwd[HI_ID];
				default:      o_tx <= '0;
			endcase
		end
	end

endmodule

// ==== rtl/ts_trigger.sv ====
`timescale 1ns/1ps

module ts_trigger (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  dim_pkg::hdr_t     i_rx_hdr,
	input  dim_pkg::hdr_t     i_host_hdr,
	output dim_pkg::ts_trig_t o_ts
);

	logic       rx_sync_req;
	logic       rx_sync_rsp;
	logic       rx_frt0;
	logic       host_sync_req;
	logic       host_sync_rsp;
	logic       host_frt0;
	logic       sync_s_lvl;
	logic       frt0_s_lvl;
	logic       send_s;
	logic       sync_m_lvl;
	logic       frt0_m_lvl;
	logic       send_m;
	logic [3:0] lvl;
	logic [3:0] lvl_d;
	logic [3:0] pulse;

	function automatic logic is_kind(
		input dim_pkg::hdr_t h,
		input logic [7:0]    frt,
		input logic [47:0]   mac
	);
		return h.valid && (h.eth_type == dim_pkg::ETH_TYPE_RT)
			&& (h.frt_type == frt) && (h.dest_mac == mac);
	endfunction

	assign rx_sync_req   = is_kind(i_rx_hdr, dim_pkg::FRT_TYPE_SYNC_REQ, dim_pkg::MAC_SYNC_REQ);
	assign rx_sync_rsp   = is_kind(i_rx_hdr, dim_pkg::FRT_TYPE_SYNC_RSP, dim_pkg::MAC_SYNC_RSP);
	assign rx_frt0       = is_kind(i_rx_hdr, dim_pkg::FRT_TYPE_FRT0, dim_pkg::MAC_BCAST);
	assign host_sync_req = is_kind(i_host_hdr, dim_pkg::FRT_TYPE_SYNC_REQ, dim_pkg::MAC_SYNC_REQ);
	assign host_sync_rsp = is_kind(i_host_hdr, dim_pkg::FRT_TYPE_SYNC_RSP, dim_pkg::MAC_SYNC_RSP);
	assign host_frt0     = is_kind(i_host_hdr, dim_pkg::FRT_TYPE_FRT0, dim_pkg::MAC_BCAST);

	// event levels, first match wins in each role
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			{sync_s_lvl, frt0_s_lvl, send_s} <= 3'b000;
			{sync_m_lvl, frt0_m_lvl, send_m} <= 3'b000;
		end
		else
		begin
			// slave role
			if (rx_sync_rsp)
				{sync_s_lvl, frt0_s_lvl, send_s} <= 3'b100;
			else if (host_sync_req)
				{sync_s_lvl, frt0_s_lvl, send_s} <= 3'b101;
			else if (rx_frt0)
				{sync_s_lvl, frt0_s_lvl, send_s} <= 3'b010;
			else
				{sync_s_lvl, frt0_s_lvl, send_s} <= 3'b000;
			// master role
			if (rx_sync_req)
				{sync_m_lvl, frt0_m_lvl, send_m} <= 3'b100;
			else if (host_frt0)
				{sync_m_lvl, frt0_m_lvl, send_m} <= 3'b011;
			else if (host_sync_rsp)
				{sync_m_lvl, frt0_m_lvl, send_m} <= 3'b101;
			else
				{sync_m_lvl, frt0_m_lvl, send_m} <= 3'b000;
		end
	end

	assign lvl = {frt0_s_lvl, sync_s_lvl, frt0_m_lvl, sync_m_lvl};

	// one-cycle pulse on each rising level
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			lvl_d <= '0;
			pulse <= '0;
		end
		else
		begin
			lvl_d <= lvl;
			pulse <= lvl & ~lvl_d;
		end
	end

	always_comb
	begin
		o_ts.frt0_s       = pulse[3];
		o_ts.sync_s       = pulse[2];
		o_ts.send_recvn_s = send_s;
		o_ts.frt0_m       = pulse[1];
		o_ts.sync_m       = pulse[0];
		o_ts.send_recvn_m = send_m;
	end

endmodule

// ==== rtl/dim_switch_top.sv ====
`timescale 1ns/1ps

module dim_switch_top #(
	parameter int FWD_DELAY = 16
) (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  logic [dim_pkg::NUM_PORTS-1:0] i_sendtrig,
	input  dim_pkg::mii_t                 i_rx   [dim_pkg::NUM_PORTS],
	input  dim_pkg::mii_t                 i_host [dim_pkg::NUM_PORTS],
	output dim_pkg::mii_t                 o_tx   [dim_pkg::NUM_PORTS],
	output dim_pkg::ts_trig_t             o_ts   [dim_pkg::NUM_PORTS]
);

	// cached rx streams, shared by all arbiters
	dim_pkg::mii_t rx_dly [dim_pkg::NUM_PORTS];

	dim_pkg::hdr_t rx_hdr   [dim_pkg::NUM_PORTS];
	dim_pkg::hdr_t host_hdr [dim_pkg::NUM_PORTS];

	// raw receive activity for the priority rule
	logic [dim_pkg::NUM_PORTS-1:0] rx_dv;

	generate
		for (genvar p = 0; p < dim_pkg::NUM_PORTS; p++)
		begin : g_port
			assign rx_dv[p] = i_rx[p].dv;

			frame_delay #(
				.FWD_DELAY(FWD_DELAY)
			) u_delay (
				.i_clk    (i_clk),
				.i_rst_n  (i_rst_n),
				.i_stream (i_rx[p]),
				.o_stream (rx_dly[p])
			);

			frame_parser u_rx_parser (
				.i_clk    (i_clk),
				.i_rst_n  (i_rst_n),
				.i_stream (i_rx[p]),
				.o_hdr    (rx_hdr[p])
			);

			// host side, for send timestamps
			frame_parser u_host_parser (
				.i_clk    (i_clk),
				.i_rst_n  (i_rst_n),
				.i_stream (i_host[p]),
				.o_hdr    (host_hdr[p])
			);

			port_tx_arbiter #(
				.PORT_ID(p)
			) u_arbiter (
				.i_clk      (i_clk),
				.i_rst_n    (i_rst_n),
				.i_sendtrig (i_sendtrig[p]),
				.i_host     (i_host[p]),
				.i_fwd      (rx_dly),
				.i_rx_dv    (rx_dv),
				.o_tx       (o_tx[p])
			);

			ts_trigger u_ts (
				.i_clk      (i_clk),
				.i_rst_n    (i_rst_n),
				.i_rx_hdr   (rx_hdr[p]),
				.i_host_hdr (host_hdr[p]),
				.o_ts       (o_ts[p])
			);
		end
	endgenerate

endmodule

// ==== test/dim_checker.sv ====
`timescale 1ns/1ps

module dim_checker #(
	parameter int FWD_DELAY = 16
) (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  logic [dim_pkg::NUM_PORTS-1:0] i_sendtrig,
	input  dim_pkg::mii_t                 i_rx   [dim_pkg::NUM_PORTS],
	input  dim_pkg::mii_t                 i_host [dim_pkg::NUM_PORTS],
	input  dim_pkg::mii_t                 i_tx   [dim_pkg::NUM_PORTS],
	input  dim_pkg::ts_trig_t             i_ts   [dim_pkg::NUM_PORTS],
	output logic                          o_busy,
	output int                            o_errors,
	output int                            o_missing
);

	localparam int NP        = dim_pkg::NUM_PORTS;
	localparam int HDR_NIBS  = dim_pkg::HDR_LAST_NIBBLE + 1;
	localparam int TS_WINDOW = 6;

	// captured streams and expected tx frames per port
	logic [3:0]        rx_cap   [NP][$];
	logic [3:0]        host_cap [NP][$];
	logic [3:0]        tx_cap   [NP][$];
	logic [3:0]        exp_nib  [NP][$];
	int                exp_len  [NP][$];
	logic [NP-1:0]     rx_prev;
	logic [NP-1:0]     host_prev;
	logic [NP-1:0]     tx_prev;
	logic [NP-1:0]     trig_prev;
	logic [NP-1:0]     host_armed;
	logic [NP-1:0]     host_take;
	logic [NP-1:0]     deciding;
	logic [NP-1:0]     fwd_mask [NP];
	int                age      [NP];
	int                win      [NP];
	dim_pkg::ts_trig_t exp_ts   [NP];
	logic [3:0]        seen     [NP];
	logic              rst_checked;
	logic              busy;
	int                err_cnt;
	int                missing_cnt;

	assign o_busy    = busy;
	assign o_errors  = err_cnt;
	assign o_missing = missing_cnt;

	// 0 none, 1 frt0 broadcast, 2 sync request, 3 sync response
	function automatic int rt_kind(input dim_pkg::hdr_t h);
		if (!h.valid || h.eth_type != dim_pkg::ETH_TYPE_RT)
			return 0;
		if (h.frt_type == dim_pkg::FRT_TYPE_FRT0 && h.dest_mac == dim_pkg::MAC_BCAST)
			return 1;
		if (h.frt_type == dim_pkg::FRT_TYPE_SYNC_REQ && h.dest_mac == dim_pkg::MAC_SYNC_REQ)
			return 2;
		if (h.frt_type == dim_pkg::FRT_TYPE_SYNC_RSP && h.dest_mac == dim_pkg::MAC_SYNC_RSP)
			return 3;
		return 0;
	endfunction

	function automatic dim_pkg::ts_trig_t expected_ts(
		input dim_pkg::hdr_t h,
		input logic          from_host
	);
		dim_pkg::ts_trig_t t;
		int                k;
		t = '0;
		k = rt_kind(h);
		if (!from_host)
		begin
			if (k == 1)
				t.frt0_s = 1'b1;
			else if (k == 2)
				t.sync_m = 1'b1;
			else if (k == 3)
				t.sync_s = 1'b1;
		end
		else if (k == 1)
		begin
			t.frt0_m       = 1'b1;
			t.send_recvn_m = 1'b1;
		end
		else if (k == 2)
		begin
			t.sync_s       = 1'b1;
			t.send_recvn_s = 1'b1;
		end
		else if (k == 3)
		begin
			t.sync_m       = 1'b1;
			t.send_recvn_m = 1'b1;
		end
		return t;
	endfunction

	// a source is held off while any lower port receives
	function automatic logic [NP-1:0] expected_forward(
		input int            src,
		input logic [NP-1:0] rx_dv
	);
		logic [NP-1:0] dest;
		dest = '1;
		dest[src] = 1'b0;
		for (int k = 0; k < src; k++)
			if (rx_dv[k])
				dest = '0;
		return dest;
	endfunction

	// nibble i sits at flat[4*i +: 4]
	function automatic dim_pkg::hdr_t decode_header(input logic [4*HDR_NIBS-1:0] flat);
		dim_pkg::hdr_t h;
		h.valid = 1'b1;
		for (int k = 0; k < 6; k++)
			h.dest_mac[47-8*k -: 8] = {flat[8*k+4 +: 4], flat[8*k +: 4]};
		h.eth_type = {flat[100 +: 4], flat[96 +: 4], flat[108 +: 4], flat[104 +: 4]};
		h.frt_type = {flat[116 +: 4], flat[112 +: 4]};
		return h;
	endfunction

	task automatic flag_error(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic open_ts_window(input int p, input logic from_host);
		logic [4*HDR_NIBS-1:0] flat;
		for (int i = 0; i < HDR_NIBS; i++)
			flat[4*i +: 4] = from_host ? host_cap[p][i] : rx_cap[p][i];
		exp_ts[p] = expected_ts(decode_header(flat), from_host);
		seen[p]   = '0;
		win[p]    = TS_WINDOW;
	endtask

	task automatic queue_expected(input int d, input int src, input logic from_host);
		int n;
		n = from_host ? host_cap[src].size() : rx_cap[src].size();
		exp_len[d].push_back(n);
		for (int i = 0; i < n; i++)
			exp_nib[d].push_back(from_host ? host_cap[src][i] : rx_cap[src][i]);
	endtask

	task automatic watch_ts(input int p);
		logic [3:0] pulses;
		logic [3:0] flags;
		logic [3:0] want;
		logic [3:0] want_flags;
		pulses     = {i_ts[p].frt0_s, i_ts[p].sync_s, i_ts[p].frt0_m, i_ts[p].sync_m};
		flags      = {{2{i_ts[p].send_recvn_s}}, {2{i_ts[p].send_recvn_m}}};
		want       = {exp_ts[p].frt0_s, exp_ts[p].sync_s, exp_ts[p].frt0_m, exp_ts[p].sync_m};
		want_flags = {{2{exp_ts[p].send_recvn_s}}, {2{exp_ts[p].send_recvn_m}}};
		for (int b = 0; b < 4; b++)
		begin
			if (pulses[b])
			begin
				if (win[p] > 0 && want[b] && !seen[p][b])
				begin
					seen[p][b] = 1'b1;
					if (flags[b] != want_flags[b])
						flag_error($sformatf("port %0d trigger bit %0d send_recvn %0b, expected %0b",
							p, b, flags[b], want_flags[b]));
				end
				else
					flag_error($sformatf("port %0d unexpected trigger pulse on bit %0d", p, b));
			end
		end
		if (win[p] > 0)
		begin
			win[p] = win[p] - 1;
			if (win[p] == 0 && (want & ~seen[p]) != 4'b0000)
				flag_error($sformatf("port %0d missing trigger pulses %b", p, want & ~seen[p]));
		end
	endtask

	task automatic watch_rx(input int p);
		logic [NP-1:0] rx_dv;
		for (int k = 0; k < NP; k++)
			rx_dv[k] = i_rx[k].dv;
		if (i_rx[p].dv && !rx_prev[p])
		begin
			rx_cap[p].delete();
			age[p]      = 0;
			deciding[p] = 1'b1;
			fwd_mask[p] = '0;
		end
		if (i_rx[p].dv)
		begin
			rx_cap[p].push_back(i_rx[p].data);
			if (rx_cap[p].size() == HDR_NIBS)
				open_ts_window(p, 1'b0);
		end
		// delayed copy starts FWD_DELAY edges after the first nibble
		if (deciding[p])
		begin
			if (age[p] == FWD_DELAY)
			begin
				fwd_mask[p] = expected_forward(p, rx_dv);
				deciding[p] = 1'b0;
			end
			else
				age[p] = age[p] + 1;
		end
		if (!i_rx[p].dv && rx_prev[p])
			for (int d = 0; d < NP; d++)
				if (fwd_mask[p][d])
					queue_expected(d, p, 1'b0);
		rx_prev[p] = i_rx[p].dv;
	endtask

	task automatic watch_host(input int p);
		if (i_sendtrig[p] && !trig_prev[p])
			host_armed[p] = 1'b1;
		if (i_host[p].dv && !host_prev[p])
		begin
			host_cap[p].delete();
			host_take[p]  = host_armed[p];
			host_armed[p] = 1'b0;
		end
		if (i_host[p].dv)
		begin
			host_cap[p].push_back(i_host[p].data);
			if (host_cap[p].size() == HDR_NIBS)
				open_ts_window(p, 1'b1);
		end
		if (!i_host[p].dv && host_prev[p] && host_take[p])
			queue_expected(p, p, 1'b1);
		trig_prev[p] = i_sendtrig[p];
		host_prev[p] = i_host[p].dv;
	endtask

	task automatic watch_tx(input int p);
		int         n;
		int         bad;
		logic [3:0] e;
		logic [3:0] bad_exp;
		if (i_tx[p].dv && !tx_prev[p])
			tx_cap[p].delete();
		if (i_tx[p].dv)
			tx_cap[p].push_back(i_tx[p].data);
		if (!i_tx[p].dv && tx_prev[p])
		begin
			if (exp_len[p].size() == 0)
				flag_error($sformatf("unexpected frame of %0d nibbles on tx port %0d",
					tx_cap[p].size(), p));
			else
			begin
				n       = exp_len[p].pop_front();
				bad     = -1;
				bad_exp = 4'h0;
				if (n != tx_cap[p].size())
					flag_error($sformatf("tx port %0d frame length %0d, expected %0d",
						p, tx_cap[p].size(), n));
				for (int i = 0; i < n; i++)
				begin
					e = exp_nib[p].pop_front();
					if (bad < 0 && i < tx_cap[p].size() && tx_cap[p][i] !== e)
					begin
						bad     = i;
						bad_exp = e;
					end
				end
				if (bad >= 0)
					flag_error($sformatf("tx port %0d nibble %0d is %h, expected %h",
						p, bad, tx_cap[p][bad], bad_exp));
			end
		end
		tx_prev[p] = i_tx[p].dv;
	endtask

	task automatic update_busy();
		busy        = 1'b0;
		missing_cnt = 0;
		for (int p = 0; p < NP; p++)
		begin
			missing_cnt += exp_len[p].size();
			if (win[p] > 0 || rx_prev[p] || host_prev[p] || tx_prev[p] || deciding[p])
				busy = 1'b1;
		end
		if (missing_cnt != 0)
			busy = 1'b1;
	endtask

	always @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			err_cnt     = 0;
			missing_cnt = 0;
			busy        = 1'b0;
			rst_checked = 1'b0;
			rx_prev     = '0;
			host_prev   = '0;
			tx_prev     = '0;
			trig_prev   = '0;
			host_armed  = '0;
			host_take   = '0;
			deciding    = '0;
			for (int p = 0; p < NP; p++)
			begin
				rx_cap[p].delete();
				host_cap[p].delete();
				tx_cap[p].delete();
				exp_nib[p].delete();
				exp_len[p].delete();
				fwd_mask[p] = '0;
				age[p]      = 0;
				win[p]      = 0;
				exp_ts[p]   = '0;
				seen[p]     = '0;
			end
		end
		else
		begin
			// first edge out of reset
			if (!rst_checked)
			begin
				for (int p = 0; p < NP; p++)
					if (i_tx[p] != '0 || i_ts[p] != '0)
						flag_error($sformatf("port %0d outputs not cleared by reset", p));
				rst_checked = 1'b1;
			end
			for (int p = 0; p < NP; p++)
			begin
				watch_ts(p);
				watch_rx(p);
				watch_host(p);
				watch_tx(p);
			end
			update_busy();
		end
	end

endmodule

// ==== test/tb_dim_switch.sv ====
`timescale 1ns/1ps

module tb_dim_switch;

	localparam int NP        = dim_pkg::NUM_PORTS;
	localparam int FWD_DELAY = 16;
	localparam int WAIT_MAX  = 400;

	logic              clk;
	logic              rst_n;
	logic [NP-1:0]     sendtrig;
	dim_pkg::mii_t     rx_drv   [NP];
	dim_pkg::mii_t     host_drv [NP];
	dim_pkg::mii_t     tx       [NP];
	dim_pkg::ts_trig_t ts       [NP];
	logic              busy;
	int                errors;
	int                missing;
	int                timeouts;
	int                seed;

	dim_switch_top #(
		.FWD_DELAY(FWD_DELAY)
	) dut (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_sendtrig (sendtrig),
		.i_rx       (rx_drv),
		.i_host     (host_drv),
		.o_tx       (tx),
		.o_ts       (ts)
	);

	dim_checker #(
		.FWD_DELAY(FWD_DELAY)
	) u_checker (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_sendtrig (sendtrig),
		.i_rx       (rx_drv),
		.i_host     (host_drv),
		.i_tx       (tx),
		.i_ts       (ts),
		.o_busy     (busy),
		.o_errors   (errors),
		.o_missing  (missing)
	);

	always #20 clk = ~clk;

	task automatic drive_nibble(input int port, input logic to_host, input dim_pkg::mii_t v);
		if (to_host)
			host_drv[port] = v;
		else
			rx_drv[port] = v;
	endtask

	// header in wire order, low nibble first, then random payload
	task automatic drive_frame(
		input int          port,
		input logic        to_host,
		input logic [47:0] mac,
		input logic [15:0] etype,
		input logic [7:0]  frt,
		input int          plen
	);
		logic [3:0]  nib [$];
		logic [47:0] src_mac;
		logic [7:0]  b;
		src_mac = 48'h0200_0000_0000 | 48'(port);
		for (int k = 5; k >= 0; k--)
		begin
			b = mac[8*k +: 8];
			nib.push_back(b[3:0]);
			nib.push_back(b[7:4]);
		end
		for (int k = 5; k >= 0; k--)
		begin
			b = src_mac[8*k +: 8];
			nib.push_back(b[3:0]);
			nib.push_back(b[7:4]);
		end
		for (int k = 1; k >= 0; k--)
		begin
			b = etype[8*k +: 8];
			nib.push_back(b[3:0]);
			nib.push_back(b[7:4]);
		end
		nib.push_back(frt[3:0]);
		nib.push_back(frt[7:4]);
		for (int i = 0; i < plen; i++)
			nib.push_back(4'($random(seed)));
		foreach (nib[i])
		begin
			@(negedge clk);
			drive_nibble(port, to_host, dim_pkg::mii_t'({1'b1, nib[i]}));
		end
		@(negedge clk);
		drive_nibble(port, to_host, '0);
	endtask

	task automatic pulse_trigger(input int port);
		@(negedge clk);
		sendtrig[port] = 1'b1;
		@(negedge clk);
		sendtrig[port] = 1'b0;
	endtask

	// until the checker has nothing in flight
	task automatic wait_quiet(input string what);
		int n;
		for (n = 0; n < WAIT_MAX; n++)
		begin
			@(negedge clk);
			if (!busy)
				break;
		end
		if (n == WAIT_MAX)
		begin
			$display("timeout: %s did not finish within %0d cycles", what, WAIT_MAX);
			timeouts++;
		end
		repeat (4) @(negedge clk);
	endtask

	initial
	begin
		seed     = 29408;
		timeouts = 0;
		clk      = 1'b0;
		rst_n    = 1'b0;
		sendtrig = '0;
		for (int p = 0; p < NP; p++)
		begin
			rx_drv[p]   = '0;
			host_drv[p] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);

		drive_frame(0, 1'b0, 48'h0010_a400_0001, 16'h0800, 8'h00, 24);
		wait_quiet("forward from port A");

		pulse_trigger(1);
		drive_frame(1, 1'b1, 48'h0010_a400_0002, 16'h0800, 8'h00, 16);
		wait_quiet("host send on port B");

		// B starts while A is still receiving
		fork
			drive_frame(0, 1'b0, 48'h0010_a400_0003, 16'h0800, 8'h00, 60);
			begin
				repeat (4) @(negedge clk);
				drive_frame(1, 1'b0, 48'h0010_a400_0004, 16'h0800, 8'h00, 10);
			end
		join
		wait_quiet("overlapping frames on A and B");

		drive_frame(2, 1'b0, 48'h0010_a400_0005, 16'h0800, 8'h00, 12);
		wait_quiet("lone frame on port C");

		// rx events on A
		drive_frame(0, 1'b0, dim_pkg::MAC_SYNC_RSP, dim_pkg::ETH_TYPE_RT,
			dim_pkg::FRT_TYPE_SYNC_RSP, 8);
		wait_quiet("rx sync response");
		drive_frame(0, 1'b0, dim_pkg::MAC_SYNC_REQ, dim_pkg::ETH_TYPE_RT,
			dim_pkg::FRT_TYPE_SYNC_REQ, 8);
		wait_quiet("rx sync request");
		drive_frame(0, 1'b0, dim_pkg::MAC_BCAST, dim_pkg::ETH_TYPE_RT,
			dim_pkg::FRT_TYPE_FRT0, 8);
		wait_quiet("rx frt0 broadcast");

		// host events on B
		drive_frame(1, 1'b1, dim_pkg::MAC_SYNC_REQ, dim_pkg::ETH_TYPE_RT,
			dim_pkg::FRT_TYPE_SYNC_REQ, 8);
		wait_quiet("host sync request");
		drive_frame(1, 1'b1, dim_pkg::MAC_BCAST, dim_pkg::ETH_TYPE_RT,
			dim_pkg::FRT_TYPE_FRT0, 8);
		wait_quiet("host frt0 broadcast");
		drive_frame(1, 1'b1, dim_pkg::MAC_SYNC_RSP, dim_pkg::ETH_TYPE_RT,
			dim_pkg::FRT_TYPE_SYNC_RSP, 8);
		wait_quiet("host sync response");

		// near misses, still forwarded
		drive_frame(0, 1'b0, dim_pkg::MAC_SYNC_REQ, 16'h0800, dim_pkg::FRT_TYPE_SYNC_REQ, 8);
		wait_quiet("wrong ethertype on A");
		drive_frame(2, 1'b0, dim_pkg::MAC_BCAST, dim_pkg::ETH_TYPE_RT,
			dim_pkg::FRT_TYPE_SYNC_REQ, 8);
		wait_quiet("wrong destination on C");

		$display("errors: mismatches=%0d missing_frames=%0d timeouts=%0d",
			errors, missing, timeouts);
		if (errors == 0 && missing == 0 && timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== filelist.f ====
rtl/dim_pkg.sv
rtl/frame_parser.sv
rtl/frame_delay.sv
rtl/port_tx_arbiter.sv
rtl/ts_trigger.sv
rtl/dim_switch_top.sv
test/dim_checker.sv
test/tb_dim_switch.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dim_switch
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
